//--- Makefile
# Verilator build and run of the retirement testbench

TOP := tb_retire

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "TESTS PASSED" sim.log && echo "result: pass" || (echo "result: fail"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- branch_retire.sv
/*
 * Branch retirement. Registers the fetch redirect when a mispredicted
 * branch commits and tallies predictor accuracy on committed branches.
 */
`timescale 1ns/1ps
`default_nettype none

module branch_retire (
    input  logic                           clock,
    input  logic                           reset,
    commit_if.view                         cmt,
    output logic                           redirect_valid,
    output logic [retire_pkg::xlen-1:0]    redirect_pc,
    output logic [retire_pkg::cnt_len-1:0] branch_count,
    output logic [retire_pkg::cnt_len-1:0] local_correct,
    output logic [retire_pkg::cnt_len-1:0] global_correct
);
    import retire_pkg::*;

    logic            cond_commit;
    logic            local_hit;
    logic            global_hit;
    logic [xlen-1:0] fall_through;

    assign cond_commit  = cmt.valid && cmt.cond_branch;
    assign local_hit    = (cmt.local_pred == cmt.taken);
    assign global_hit   = (cmt.global_pred == cmt.taken);
    assign fall_through = cmt.pc + xlen'(inst_bytes);

    //////////////////////////////////////////////////
    // redirect
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            redirect_valid <= cmt.mis_pred_head;  // one cycle after the flush edge
            if (cmt.mis_pred_head) begin
                redirect_pc <= cmt.taken ? cmt.target : fall_through;
            end
        end
    end

    //////////////////////////////////////////////////
    // accuracy counters, wrap at cnt_len
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            branch_count   <= '0;
            local_correct  <= '0;
            global_correct <= '0;
        end else if (cond_commit) begin
            branch_count <= branch_count + 1'b1;
            if (local_hit) local_correct <= local_correct + 1'b1;
            if (global_hit) global_correct <= global_correct + 1'b1;
        end
    end

    // the flush empties the buffer, so no second redirect can follow at once
    assert property (@(posedge clock) disable iff (reset) redirect_valid |=> !redirect_valid)
        else $error("branch_retire: back to back redirect");

    // dispatch marks a branch as one kind only
    assert property (@(posedge clock) disable iff (reset)
        cmt.valid |-> !(cmt.cond_branch && cmt.uncond_branch))
        else $error("branch_retire: entry both conditional and unconditional");

endmodule

`default_nettype wire

//--- commit_if.sv
/*
 * Head entry of the reorder buffer as seen by the retirement consumers.
 * The entry retires at every edge where valid is high.
 */
`timescale 1ns/1ps
`default_nettype none

interface commit_if;
    import retire_pkg::*;

    logic                valid;
    logic [areg_len-1:0] dest_areg;
    logic [prf_len-1:0]  dest_preg;
    logic [xlen-1:0]     pc;
    logic                cond_branch;
    logic                uncond_branch;
    logic [xlen-1:0]     target;
    logic                local_pred;
    logic                global_pred;
    logic                taken;
    logic                mis_pred_head;  // flush at the next edge
    logic                illegal;
    logic                halt;

    modport src (
        output valid, dest_areg, dest_preg, pc, cond_branch, uncond_branch, target,
               local_pred, global_pred, taken, mis_pred_head, illegal, halt
    );

    modport view (
        input  valid, dest_areg, dest_preg, pc, cond_branch, uncond_branch, target,
               local_pred, global_pred, taken, mis_pred_head, illegal, halt
    );

endinterface

`default_nettype wire

//--- complete_if.sv
/*
 * Completion broadcast into the reorder buffer, one pulse per cycle
 * with no acknowledge.
 */
`timescale 1ns/1ps
`default_nettype none

interface complete_if;
    import retire_pkg::*;

    logic               valid;
    logic [rob_len-1:0] rob_idx;   // entry that finished
    logic               taken;     // resolved branch direction
    logic [xlen-1:0]    target;
    logic               mis_pred;

    modport src (
        output valid, rob_idx, taken, target, mis_pred
    );

    modport sink (
        input  valid, rob_idx, taken, target, mis_pred
    );

endinterface

`default_nettype wire

//--- dispatch_if.sv
/*
 * Dispatch path into the reorder buffer. The producer holds valid low
 * while full is high; the written entry gets the tail index of that cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface dispatch_if;
    import retire_pkg::*;

    logic                valid;
    logic [xlen-1:0]     pc;
    logic [areg_len-1:0] dest_areg;
    logic [prf_len-1:0]  dest_preg;
    logic                cond_branch;
    logic                uncond_branch;
    logic                local_pred;   // local predictor direction
    logic                global_pred;  // global predictor direction
    logic                illegal;
    logic                halt;

    // back from the buffer
    logic [rob_len-1:0]  tail;
    logic                full;

    modport src (
        output valid, pc, dest_areg, dest_preg, cond_branch, uncond_branch,
               local_pred, global_pred, illegal, halt,
        input  tail, full
    );

    modport sink (
        input  valid, pc, dest_areg, dest_preg, cond_branch, uncond_branch,
               local_pred, global_pred, illegal, halt,
        output tail, full
    );

endinterface

`default_nettype wire

//--- retire_pkg.sv
/*
 * Shared sizes and constants for the retirement side of the core.
 * Modules import it in their bodies and use scoped names in port lists.
 */
`default_nettype none

package retire_pkg;

    //////////////////////////////////////////////////
    // datapath widths
    //////////////////////////////////////////////////

    localparam int unsigned xlen       = 32;  // pc and branch target
    localparam int unsigned areg_len   = 5;   // architectural register index
    localparam int unsigned areg_count = 32;
    localparam int unsigned prf_len    = 6;   // 64 physical registers

    //////////////////////////////////////////////////
    // reorder buffer geometry
    //////////////////////////////////////////////////

    localparam int unsigned rob_size = 8;
    localparam int unsigned rob_len  = 3;     // index into the buffer

    // predictor accuracy counters wrap at this width
    localparam int unsigned cnt_len = 16;

    //////////////////////////////////////////////////
    // constants
    //////////////////////////////////////////////////

    // fall-through step for a not-taken branch
    localparam int unsigned inst_bytes = 4;

    // target held by an entry until its completion writes a real one
    localparam logic [xlen-1:0] pc_poison = 32'hfacefeed;

endpackage

`default_nettype wire

//--- retire_rat.sv
/*
 * Retirement alias table. Holds the committed architectural to physical
 * mapping, written on commit, with one combinational read port.
 */
`timescale 1ns/1ps
`default_nettype none

module retire_rat (
    input  logic                            clock,
    input  logic                            reset,
    commit_if.view                          cmt,
    input  logic [retire_pkg::areg_len-1:0] read_areg,
    output logic [retire_pkg::prf_len-1:0]  read_preg
);
    import retire_pkg::*;

    logic [prf_len-1:0] map [areg_count];
    logic               write_en;

    // x0 is never remapped
    assign write_en = cmt.valid && (cmt.dest_areg != '0);

    //////////////////////////////////////////////////
    // committed map
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < areg_count; i++) begin
                map[i] <= prf_len'(i);  // identity after reset
            end
        end else if (write_en) begin
            map[cmt.dest_areg] <= cmt.dest_preg;
        end
    end

    assign read_preg = map[read_areg];  // new mapping visible the cycle after commit

    // x0 stays on p0 for the whole run
    assert property (@(posedge clock) disable iff (reset) map[0] == '0)
        else $error("retire_rat: x0 lost its identity mapping");

endmodule

`default_nettype wire

//--- retire_top.sv
/*
 * Top level of the retirement side. Maps plain ports onto the internal
 * interfaces and connects the reorder buffer, map table and branch unit.
 */
`timescale 1ns/1ps
`default_nettype none

module retire_top (
    input  logic                            clock,
    input  logic                            reset,
    // dispatch
    input  logic                            disp_valid,
    input  logic [retire_pkg::xlen-1:0]     disp_pc,
    input  logic [retire_pkg::areg_len-1:0] disp_dest_areg,
    input  logic [retire_pkg::prf_len-1:0]  disp_dest_preg,
    input  logic                            disp_cond_branch,
    input  logic                            disp_uncond_branch,
    input  logic                            disp_local_pred,
    input  logic                            disp_global_pred,
    input  logic                            disp_illegal,
    input  logic                            disp_halt,
    // completion broadcast
    input  logic                            cmpl_valid,
    input  logic [retire_pkg::rob_len-1:0]  cmpl_rob_idx,
    input  logic                            cmpl_taken,
    input  logic [retire_pkg::xlen-1:0]     cmpl_target,
    input  logic                            cmpl_mis_pred,
    // buffer status and commit
    output logic [retire_pkg::rob_len-1:0]  rob_tail,
    output logic                            rob_full,
    output logic                            commit_valid,
    output logic [retire_pkg::xlen-1:0]     commit_pc,
    output logic [retire_pkg::areg_len-1:0] commit_dest_areg,
    output logic [retire_pkg::prf_len-1:0]  commit_dest_preg,
    output logic                            commit_halt,
    output logic                            commit_illegal,
    // map read port
    input  logic [retire_pkg::areg_len-1:0] read_areg,
    output logic [retire_pkg::prf_len-1:0]  read_preg,
    // redirect and predictor stats
    output logic                            redirect_valid,
    output logic [retire_pkg::xlen-1:0]     redirect_pc,
    output logic [retire_pkg::cnt_len-1:0]  branch_count,
    output logic [retire_pkg::cnt_len-1:0]  local_correct,
    output logic [retire_pkg::cnt_len-1:0]  global_correct
);

    dispatch_if disp ();
    complete_if cmpl ();
    commit_if   cmt ();

    assign disp.valid         = disp_valid;
    assign disp.pc            = disp_pc;
    assign disp.dest_areg     = disp_dest_areg;
    assign disp.dest_preg     = disp_dest_preg;
    assign disp.cond_branch   = disp_cond_branch;
    assign disp.uncond_branch = disp_uncond_branch;
    assign disp.local_pred    = disp_local_pred;
    assign disp.global_pred   = disp_global_pred;
    assign disp.illegal       = disp_illegal;
    assign disp.halt          = disp_halt;

    assign cmpl.valid    = cmpl_valid;
    assign cmpl.rob_idx  = cmpl_rob_idx;
    assign cmpl.taken    = cmpl_taken;
    assign cmpl.target   = cmpl_target;
    assign cmpl.mis_pred = cmpl_mis_pred;

    assign rob_tail         = disp.tail;
    assign rob_full         = disp.full;
    assign commit_valid     = cmt.valid;
    assign commit_pc        = cmt.pc;
    assign commit_dest_areg = cmt.dest_areg;
    assign commit_dest_preg = cmt.dest_preg;
    assign commit_halt      = cmt.halt;
    assign commit_illegal   = cmt.illegal;

    rob u_rob (
        .clock (clock),
        .reset (reset),
        .disp  (disp),
        .cmpl  (cmpl),
        .cmt   (cmt)
    );

    retire_rat u_rat (
        .clock     (clock),
        .reset     (reset),
        .cmt       (cmt),
        .read_areg (read_areg),
        .read_preg (read_preg)
    );

    branch_retire u_branch (
        .clock          (clock),
        .reset          (reset),
        .cmt            (cmt),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .branch_count   (branch_count),
        .local_correct  (local_correct),
        .global_correct (global_correct)
    );

endmodule

`default_nettype wire

//--- rob.sv
/*
 * Circular reorder buffer. Dispatch writes at the tail, completion marks
 * an entry executed, the executed head commits, and a mispredicted branch
 * at the head empties the whole buffer.
 */
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  logic     clock,
    input  logic     reset,
    dispatch_if.sink disp,
    complete_if.sink cmpl,
    commit_if.src    cmt
);
    import retire_pkg::*;

    //////////////////////////////////////////////////
    // entry storage, one array per field
    //////////////////////////////////////////////////

    logic [xlen-1:0]     pc_q          [rob_size];
    logic [areg_len-1:0] dest_areg_q   [rob_size];
    logic [prf_len-1:0]  dest_preg_q   [rob_size];
    logic [xlen-1:0]     target_q      [rob_size];
    logic [rob_size-1:0] cond_branch_q;
    logic [rob_size-1:0] uncond_branch_q;
    logic [rob_size-1:0] local_pred_q;
    logic [rob_size-1:0] global_pred_q;
    logic [rob_size-1:0] illegal_q;
    logic [rob_size-1:0] halt_q;
    logic [rob_size-1:0] taken_q;
    logic [rob_size-1:0] mis_pred_q;
    logic [rob_size-1:0] executed_q;

    logic [rob_len-1:0]  head;
    logic [rob_len-1:0]  tail;
    logic [rob_len:0]    count;        // occupancy, 0..rob_size
    logic                empty;
    logic                full;
    logic                flush;
    logic [rob_len-1:0]  cmpl_offset;  // distance of completion from head

    function automatic logic [rob_len-1:0] next_idx(input logic [rob_len-1:0] idx);
        return (idx == rob_len'(rob_size - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == (rob_len + 1)'(rob_size));
    assign flush = cmt.mis_pred_head;

    assign disp.tail = tail;
    assign disp.full = full;

    //////////////////////////////////////////////////
    // head entry out to the consumers
    //////////////////////////////////////////////////

    assign cmt.valid         = !empty && executed_q[head];
    assign cmt.dest_areg     = dest_areg_q[head];
    assign cmt.dest_preg     = dest_preg_q[head];
    assign cmt.pc            = pc_q[head];
    assign cmt.cond_branch   = cond_branch_q[head];
    assign cmt.uncond_branch = uncond_branch_q[head];
    assign cmt.target        = target_q[head];
    assign cmt.local_pred    = local_pred_q[head];
    assign cmt.global_pred   = global_pred_q[head];
    assign cmt.taken         = taken_q[head];
    assign cmt.mis_pred_head = mis_pred_q[head] && cmt.valid;
    assign cmt.illegal       = illegal_q[head] && cmt.valid;
    assign cmt.halt          = halt_q[head] && cmt.valid;

    //////////////////////////////////////////////////
    // pointers, occupancy and executed bits
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            executed_q <= '0;
        end else if (flush) begin
            // drop everything younger, tail stays put
            head  <= tail;
            count <= '0;
        end else begin
            if (disp.valid) begin
                executed_q[tail] <= disp.illegal | disp.halt;  // nothing to wait for
                tail             <= next_idx(tail);
            end
            if (cmpl.valid) begin
                executed_q[cmpl.rob_idx] <= 1'b1;
            end
            if (cmt.valid) begin
                head <= next_idx(head);
            end
            case ({disp.valid, cmt.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload fields
    always_ff @(posedge clock) begin
        if (!flush && disp.valid) begin
            pc_q[tail]            <= disp.pc;
            dest_areg_q[tail]     <= disp.dest_areg;
            dest_preg_q[tail]     <= disp.dest_preg;
            cond_branch_q[tail]   <= disp.cond_branch;
            uncond_branch_q[tail] <= disp.uncond_branch;
            local_pred_q[tail]    <= disp.local_pred;
            global_pred_q[tail]   <= disp.global_pred;
            illegal_q[tail]       <= disp.illegal;
            halt_q[tail]          <= disp.halt;
            target_q[tail]        <= pc_poison;  // overwritten at completion
            taken_q[tail]         <= 1'b0;
            mis_pred_q[tail]      <= 1'b0;
        end
        if (!flush && cmpl.valid) begin
            taken_q[cmpl.rob_idx]    <= cmpl.taken;
            target_q[cmpl.rob_idx]   <= cmpl.target;
            mis_pred_q[cmpl.rob_idx] <= cmpl.mis_pred;
        end
    end

    //////////////////////////////////////////////////
    // checks on the producers
    //////////////////////////////////////////////////

    assign cmpl_offset = cmpl.rob_idx - head;

    // dispatch has to honour full
    assert property (@(posedge clock) disable iff (reset) disp.valid |-> !full)
        else $error("rob: dispatch while full");

    // completion must name a live entry
    assert property (@(posedge clock) disable iff (reset)
        cmpl.valid |-> ({1'b0, cmpl_offset} < count))
        else $error("rob: completion to unoccupied index %0d", cmpl.rob_idx);

endmodule

`default_nettype wire

//--- sources.f
retire_pkg.sv
dispatch_if.sv
complete_if.sv
commit_if.sv
rob.sv
retire_rat.sv
branch_retire.sv
retire_top.sv
tb_retire.sv

//--- tb_retire.sv
/*
 * Testbench for retire_top. Plays dispatch and the completion bus, keeps a
 * reference model of the buffer, map and predictor tallies, checks commits.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_retire;
    import retire_pkg::*;

    localparam int wait_limit = 400;  // cycles per wait loop

    logic                clock;
    logic                reset;
    logic                disp_valid;
    logic [xlen-1:0]     disp_pc;
    logic [areg_len-1:0] disp_dest_areg;
    logic [prf_len-1:0]  disp_dest_preg;
    logic                disp_cond_branch, disp_uncond_branch;
    logic                disp_local_pred, disp_global_pred;
    logic                disp_illegal, disp_halt;
    logic                cmpl_valid, cmpl_taken, cmpl_mis_pred;
    logic [rob_len-1:0]  cmpl_rob_idx;
    logic [xlen-1:0]     cmpl_target;
    logic [rob_len-1:0]  rob_tail;
    logic                rob_full, commit_valid, commit_halt, commit_illegal;
    logic [xlen-1:0]     commit_pc;
    logic [areg_len-1:0] commit_dest_areg, read_areg;
    logic [prf_len-1:0]  commit_dest_preg, read_preg;
    logic                redirect_valid;
    logic [xlen-1:0]     redirect_pc;
    logic [cnt_len-1:0]  branch_count, local_correct, global_correct;

    retire_top uut (.*);

    //////////////////////////////////////////////////
    // reference model, one slot per buffer entry
    //////////////////////////////////////////////////

    logic [xlen-1:0]     m_pc     [rob_size];
    logic [areg_len-1:0] m_areg   [rob_size];
    logic [prf_len-1:0]  m_preg   [rob_size];
    logic [xlen-1:0]     m_target [rob_size];
    logic [rob_size-1:0] m_cond, m_lpred, m_gpred, m_illegal, m_halt, m_taken, m_mis;
    int                  order_q [$];            // live slots, oldest first
    int                  model_tail;
    logic [prf_len-1:0]  shadow_map [areg_count];
    int                  tally_branch, tally_local, tally_global;
    logic                redirect_due;
    logic [xlen-1:0]     redirect_exp;
    int                  redirect_seen, commit_seen, head_idx;
    logic [31:0]         seed;
    string               test_name;
    int                  tests, checks, errors, errors_at_start;
    int                  slots [rob_size];

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // head record as the retirement rules say it must look
    function automatic logic [63:0] expected_commit(input int idx);
        return {19'd0, m_pc[idx], m_areg[idx], m_preg[idx], m_halt[idx], m_illegal[idx]};
    endfunction

    function automatic logic [xlen-1:0] expected_redirect(input int idx);
        return m_taken[idx] ? m_target[idx] : m_pc[idx] + 32'd4;  // fall-through if not taken
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("%s: timed out waiting for %s", test_name, what);
    endtask

    //////////////////////////////////////////////////
    // compare process, runs at every edge
    //////////////////////////////////////////////////

    always @(posedge clock) begin
        if (!reset) begin
            check_value("redirect_valid", 64'(redirect_due), 64'(redirect_valid));
            if (redirect_due) begin
                check_value("redirect_pc", 64'(redirect_exp), 64'(redirect_pc));
                redirect_seen++;
            end
            redirect_due = 1'b0;
            if (commit_valid && order_q.size() == 0) begin
                errors++;
                $display("%s: commit seen with no live entry in the model", test_name);
            end else if (commit_valid) begin
                head_idx = order_q.pop_front();
                commit_seen++;
                check_value("commit record", expected_commit(head_idx),
                            {19'd0, commit_pc, commit_dest_areg, commit_dest_preg,
                             commit_halt, commit_illegal});
                if (m_areg[head_idx] != '0) shadow_map[m_areg[head_idx]] = m_preg[head_idx];
                if (m_cond[head_idx]) begin
                    tally_branch++;
                    if (m_lpred[head_idx] == m_taken[head_idx]) tally_local++;
                    if (m_gpred[head_idx] == m_taken[head_idx]) tally_global++;
                end
                if (m_mis[head_idx]) begin
                    order_q.delete();  // younger entries are gone
                    redirect_due = 1'b1;
                    redirect_exp = expected_redirect(head_idx);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // dispatch and completion drivers
    //////////////////////////////////////////////////

    task automatic dispatch(input logic [areg_len-1:0] areg, input logic [prf_len-1:0] preg,
                            input logic cond, input logic ill, input logic hlt,
                            output int slot);
        int          n;
        logic [31:0] r;
        n = 0;
        r = next_rand();
        @(negedge clock);
        while (rob_full && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (n >= wait_limit) report_timeout("room in the buffer");
        check_value("rob_tail", 64'(model_tail), 64'(rob_tail));
        @(posedge clock);
        disp_valid         <= 1'b1;
        disp_pc            <= {r[31:2], 2'b00};
        disp_dest_areg     <= areg;
        disp_dest_preg     <= preg;
        disp_cond_branch   <= cond;
        disp_uncond_branch <= 1'b0;
        disp_local_pred    <= r[0];
        disp_global_pred   <= r[1];
        disp_illegal       <= ill;
        disp_halt          <= hlt;
        slot               = model_tail;
        m_pc[slot]         = {r[31:2], 2'b00};
        m_areg[slot]       = areg;
        m_preg[slot]       = preg;
        m_cond[slot]       = cond;
        m_lpred[slot]      = r[0];
        m_gpred[slot]      = r[1];
        m_illegal[slot]    = ill;
        m_halt[slot]       = hlt;
        m_taken[slot]      = 1'b0;
        m_mis[slot]        = 1'b0;
        m_target[slot]     = pc_poison;
        order_q.push_back(slot);
        model_tail = (model_tail + 1) % rob_size;
        @(posedge clock);
        disp_valid <= 1'b0;
    endtask

    task automatic complete(input int slot, input logic taken, input logic mis);
        logic [xlen-1:0] target;
        target = next_rand() & 32'hffff_fffc;
        @(posedge clock);
        cmpl_valid     <= 1'b1;
        cmpl_rob_idx   <= rob_len'(slot);
        cmpl_taken     <= taken;
        cmpl_target    <= target;
        cmpl_mis_pred  <= mis;
        m_taken[slot]  = taken;
        m_target[slot] = target;
        m_mis[slot]    = mis;
        @(posedge clock);
        cmpl_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (order_q.size() != 0 && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (order_q.size() != 0) report_timeout("the buffer to drain");
        @(negedge clock);
    endtask

    task automatic wait_events(input bit redirects, input int target, input string what);
        int n;
        n = 0;
        while (((redirects ? redirect_seen : commit_seen) < target) && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (n >= wait_limit) report_timeout(what);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errors_at_start) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, errors - errors_at_start);
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        int          i;
        int          j;
        int          k;
        int          tmp;
        logic [31:0] r;
        seed = 32'hc979_7e41;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp_pc = '0;
        disp_dest_areg = '0;
        disp_dest_preg = '0;
        disp_cond_branch = 1'b0;
        disp_uncond_branch = 1'b0;
        disp_local_pred = 1'b0;
        disp_global_pred = 1'b0;
        disp_illegal = 1'b0;
        disp_halt = 1'b0;
        cmpl_valid = 1'b0;
        cmpl_rob_idx = '0;
        cmpl_taken = 1'b0;
        cmpl_target = '0;
        cmpl_mis_pred = 1'b0;
        read_areg = '0;
        for (i = 0; i < areg_count; i++) shadow_map[i] = prf_len'(i);  // identity after reset
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        start_test("in_order");
        for (i = 0; i < rob_size; i++) begin
            r = next_rand();
            dispatch(r[4:0], r[10:5], 1'b0, 1'b0, 1'b0, slots[i]);
        end
        for (i = rob_size - 1; i > 0; i--) begin  // shuffle completion order
            j = next_rand() % (i + 1);
            tmp = slots[i];
            slots[i] = slots[j];
            slots[j] = tmp;
        end
        for (i = 0; i < rob_size; i++) complete(slots[i], 1'b0, 1'b0);
        wait_drain();
        end_test();

        start_test("full_flag");
        for (i = 0; i < rob_size; i++) begin
            r = next_rand();
            dispatch(r[4:0], r[10:5], 1'b0, 1'b0, 1'b0, slots[i]);
        end
        @(negedge clock);
        check_value("rob_full when filled", 64'd1, 64'(rob_full));
        j = commit_seen;
        complete(slots[0], 1'b0, 1'b0);
        wait_events(1'b0, j + 1, "the first commit");
        check_value("rob_full after one commit", 64'd0, 64'(rob_full));
        for (i = 1; i < rob_size; i++) complete(slots[i], 1'b0, 1'b0);
        wait_drain();
        end_test();

        start_test("illegal_halt");
        r = next_rand();
        dispatch(r[4:0], r[10:5], 1'b0, 1'b1, 1'b0, slots[0]);
        dispatch(r[9:5], r[15:10], 1'b0, 1'b0, 1'b1, slots[1]);
        dispatch(r[14:10], r[20:15], 1'b0, 1'b1, 1'b1, slots[2]);
        wait_drain();
        end_test();

        start_test("retire_map");
        for (i = 0; i < 12; i++) begin
            r = next_rand();
            dispatch({2'b00, r[2:0]}, r[10:5], 1'b0, 1'b0, 1'b0, slots[0]);  // x0..x7 reused
            complete(slots[0], 1'b0, 1'b0);
        end
        wait_drain();
        for (i = 0; i < areg_count; i++) begin
            @(posedge clock);
            read_areg <= areg_len'(i);
            @(negedge clock);
            check_value($sformatf("read_preg x%0d", i), 64'(shadow_map[i]), 64'(read_preg));
        end
        end_test();

        start_test("flush");
        for (k = 0; k < 2; k++) begin
            r = next_rand();
            dispatch(r[4:0], r[10:5], 1'b0, 1'b0, 1'b0, slots[0]);
            dispatch(r[9:5], r[15:10], 1'b1, 1'b0, 1'b0, slots[1]);   // the branch
            for (i = 2; i < rob_size; i++) begin
                r = next_rand();
                dispatch(r[4:0], r[10:5], 1'b0, 1'b0, 1'b0, slots[i]);
            end
            for (i = 2; i < rob_size; i++) complete(slots[i], 1'b0, 1'b0);
            complete(slots[0], 1'b0, 1'b0);
            r = next_rand();
            dispatch(r[4:0], r[10:5], 1'b0, 1'b0, 1'b0, slots[0]);  // refills the freed slot
            @(negedge clock);
            check_value("rob_full before flush", 64'd1, 64'(rob_full));
            j = redirect_seen;
            complete(slots[1], k[0], 1'b1);  // taken on the second pass
            wait_events(1'b1, j + 1, "the redirect");
            check_value("rob_full after flush", 64'd0, 64'(rob_full));
            for (i = 0; i < 2; i++) begin
                r = next_rand();
                dispatch(r[4:0], r[10:5], 1'b0, 1'b0, 1'b0, slots[i]);
                complete(slots[i], 1'b0, 1'b0);
            end
            wait_drain();
        end
        end_test();

        start_test("predictor");
        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 4; j++) begin
                r = next_rand();
                dispatch(r[4:0], r[10:5], 1'b1, 1'b0, 1'b0, slots[j]);
            end
            for (j = 0; j < 4; j++) begin
                r = next_rand();
                complete(slots[j], r[7], 1'b0);
            end
            wait_drain();
        end
        check_value("branch_count", 64'(tally_branch), 64'(branch_count));
        check_value("local_correct", 64'(tally_local), 64'(local_correct));
        check_value("global_correct", 64'(tally_global), 64'(global_correct));
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
